// File: usb_desc_defines.svh
// USB descriptor ROM defines
`ifndef USB_DESC_DEFINES_SVH
`define USB_DESC_DEFINES_SVH

`define USB_VENDOR_ID        16'h33AA          // default idVendor
`define USB_PRODUCT_ID       16'h0120          // default idProduct
`define USB_VERSION_BCD      16'h0100          // bcdDevice
`define USB_SELF_POWERED     0                 // 1 gives bmAttributes c0

`define USB_VENDOR_STR       "PSPOD"
`define USB_PRODUCT_STR      "USB Module"
`define USB_SERIAL_STR       "1"
`define USB_VENDOR_STR_LEN   5                 // characters
`define USB_PRODUCT_STR_LEN  10
`define USB_SERIAL_STR_LEN   1

`define DESC_ADDR_W          10                // rom address width

// rom layout, base address and byte count per descriptor
`define DESC_DEV_ADDR        0
`define DESC_DEV_LEN         18
`define DESC_QUAL_ADDR       20                // after 2 pad bytes
`define DESC_QUAL_LEN        10
`define DESC_HSCFG_ADDR      32                // after 2 pad bytes
`define DESC_HSCFG_LEN       109
`define DESC_STRLANG_ADDR    (`DESC_HSCFG_ADDR + `DESC_HSCFG_LEN)
`define DESC_STRLANG_LEN     4
`define DESC_STRVENDOR_ADDR  (`DESC_STRLANG_ADDR + `DESC_STRLANG_LEN)
`define DESC_STRVENDOR_LEN   (2 + 2 * `USB_VENDOR_STR_LEN)
`define DESC_STRPRODUCT_ADDR (`DESC_STRVENDOR_ADDR + `DESC_STRVENDOR_LEN)
`define DESC_STRPRODUCT_LEN  (2 + 2 * `USB_PRODUCT_STR_LEN)
`define DESC_STRSERIAL_ADDR  (`DESC_STRPRODUCT_ADDR + `DESC_STRPRODUCT_LEN)
`define DESC_STRSERIAL_LEN   (2 + 2 * `USB_SERIAL_STR_LEN)
`define DESC_END_ADDR        (`DESC_STRSERIAL_ADDR + `DESC_STRSERIAL_LEN)

`endif

// File: usb_std_pkg.sv
// USB standard codes
package usb_std_pkg;

    // bDescriptorType
    typedef enum logic [7:0] {
        DT_DEVICE    = 8'h01,
        DT_CONFIG    = 8'h02,
        DT_STRING    = 8'h03,
        DT_INTERFACE = 8'h04,
        DT_ENDPOINT  = 8'h05,
        DT_QUALIFIER = 8'h06,
        DT_IAD       = 8'h0B   // interface association
    } desc_type_e;

    // class codes in use
    typedef enum logic [7:0] {
        CLASS_NONE = 8'h00,
        CLASS_CDC  = 8'h02,
        CLASS_MISC = 8'hEF     // device class when an IAD is present
    } usb_class_e;

    // subclass and protocol share values with class, so plain constants
    localparam logic [7:0] CDC_SUBCLASS_ACM = 8'h02;
    localparam logic [7:0] IAD_SUBCLASS     = 8'h02;  // common class
    localparam logic [7:0] IAD_PROTOCOL     = 8'h01;  // interface association

endpackage

// File: desc_map_pkg.sv
// descriptor ROM addressing types
`include "usb_desc_defines.svh"

package desc_map_pkg;

    typedef logic [`DESC_ADDR_W-1:0] desc_addr_t;  // rom byte address
    typedef logic [7:0]              desc_byte_t;  // rom data and offsets

    // region hit by a rom address
    typedef enum logic [2:0] {
        REG_DEV,
        REG_QUAL,
        REG_HSCFG,
        REG_LANG,
        REG_VENDOR,
        REG_PRODUCT,
        REG_SERIAL,
        REG_NONE       // padding or past the end
    } desc_region_e;

    // ascii payloads, first character in the top byte
    typedef logic [8*`USB_VENDOR_STR_LEN-1:0]  vendor_text_t;
    typedef logic [8*`USB_PRODUCT_STR_LEN-1:0] product_text_t;
    typedef logic [8*`USB_SERIAL_STR_LEN-1:0]  serial_text_t;

endpackage

// File: dev_desc_gen.sv
// device and qualifier descriptors
`timescale 1ns/10ps
`include "usb_desc_defines.svh"

module dev_desc_gen (
    input  logic                     CLK,
    input  logic                     RESET,          // loads default ids
    input  logic [15:0]              i_vid,          // run-time idVendor
    input  logic [15:0]              i_pid,          // run-time idProduct
    input  desc_map_pkg::desc_byte_t i_dev_offset,   // index into device desc
    input  desc_map_pkg::desc_byte_t i_qual_offset,  // index into qualifier
    output desc_map_pkg::desc_byte_t o_dev_byte,
    output desc_map_pkg::desc_byte_t o_qual_byte
);

    localparam logic [15:0] BCD = `USB_VERSION_BCD;  // bcdDevice

    logic [15:0] vid_q;  // stored idVendor
    logic [15:0] pid_q;  // stored idProduct

    // 0000 and ffff mean not programmed so the defaults load
    always_ff @(posedge CLK or posedge RESET) begin
        if (RESET) begin
            vid_q <= `USB_VENDOR_ID;
            pid_q <= `USB_PRODUCT_ID;
        end else begin
            vid_q <= (i_vid != 16'h0000 && i_vid != 16'hFFFF) ? i_vid : `USB_VENDOR_ID;
            pid_q <= (i_pid != 16'h0000 && i_pid != 16'hFFFF) ? i_pid : `USB_PRODUCT_ID;
        end
    end

    always_comb begin
        case (i_dev_offset)
            8'd0:    o_dev_byte = desc_map_pkg::desc_byte_t'(`DESC_DEV_LEN);
            8'd1:    o_dev_byte = usb_std_pkg::DT_DEVICE;
            8'd2:    o_dev_byte = 8'h00;                       // bcdUSB 2.00
            8'd3:    o_dev_byte = 8'h02;
            8'd4:    o_dev_byte = usb_std_pkg::CLASS_MISC;     // iad device
            8'd5:    o_dev_byte = usb_std_pkg::IAD_SUBCLASS;
            8'd6:    o_dev_byte = usb_std_pkg::IAD_PROTOCOL;
            8'd7:    o_dev_byte = 8'h40;                       // ep0 64 bytes
            8'd8:    o_dev_byte = vid_q[7:0];                  // idVendor lo
            8'd9:    o_dev_byte = vid_q[15:8];
            8'd10:   o_dev_byte = pid_q[7:0];                  // idProduct lo
            8'd11:   o_dev_byte = pid_q[15:8];
            8'd12:   o_dev_byte = BCD[7:0];
            8'd13:   o_dev_byte = BCD[15:8];
            8'd14:   o_dev_byte = 8'h01;                       // iManufacturer
            8'd15:   o_dev_byte = 8'h02;                       // iProduct
            8'd16:   o_dev_byte = 8'h03;                       // iSerialNumber
            8'd17:   o_dev_byte = 8'h01;                       // one config
            default: o_dev_byte = 8'h00;
        endcase
    end

    always_comb begin
        case (i_qual_offset)
            8'd0:    o_qual_byte = desc_map_pkg::desc_byte_t'(`DESC_QUAL_LEN);
            8'd1:    o_qual_byte = usb_std_pkg::DT_QUALIFIER;
            8'd2:    o_qual_byte = 8'h00;                      // bcdUSB 2.00
            8'd3:    o_qual_byte = 8'h02;
            8'd4:    o_qual_byte = usb_std_pkg::CLASS_MISC;
            8'd5:    o_qual_byte = usb_std_pkg::IAD_SUBCLASS;
            8'd6:    o_qual_byte = usb_std_pkg::IAD_PROTOCOL;
            8'd7:    o_qual_byte = 8'h40;
            8'd8:    o_qual_byte = 8'h01;                      // other-speed configs
            default: o_qual_byte = 8'h00;                      // bReserved too
        endcase
    end

    // the host must never see an unprogrammed id
    a_ids_valid: assert property (@(posedge CLK) disable iff (RESET)
        !(vid_q inside {16'h0000, 16'hFFFF}) && !(pid_q inside {16'h0000, 16'hFFFF}))
        else $error("stored vid/pid holds 0000 or ffff");

endmodule

// File: hs_cfg_desc.sv
// high-speed configuration descriptor
`timescale 1ns/10ps
`include "usb_desc_defines.svh"

module hs_cfg_desc (
    input  desc_map_pkg::desc_byte_t i_offset,  // 0..108
    output desc_map_pkg::desc_byte_t o_byte
);

    localparam int IAD_START = 9;                // after config header
    localparam int IF_START  = IAD_START + 8;    // first interface group
    localparam int IF_LEN    = 23;               // interface + two endpoints

    localparam logic [15:0] TOTAL_LEN = `DESC_HSCFG_LEN;

    always_comb begin
        int  rel;        // offset inside interface group
        int  ep;         // offset inside endpoint
        logic [7:0] n;   // interface number
        logic is_out;    // second endpoint of the pair
        logic cdc;       // interfaces 1 and 2 are cdc

        rel    = 0;
        n      = 8'h00;
        o_byte = 8'h00;  // also beyond 108
        for (int g = 0; g < 4; g++) begin
            if (i_offset >= IF_START + g * IF_LEN && i_offset < IF_START + (g + 1) * IF_LEN) begin
                rel = int'(i_offset) - (IF_START + g * IF_LEN);
                n   = 8'(g);
            end
        end
        is_out = rel >= 16;
        ep     = is_out ? rel - 16 : rel - 9;
        cdc    = (n == 8'd1) || (n == 8'd2);

        if (i_offset < IAD_START) begin
            case (i_offset)
                8'd0: o_byte = 8'h09;
                8'd1: o_byte = usb_std_pkg::DT_CONFIG;
                8'd2: o_byte = TOTAL_LEN[7:0];                     // wTotalLength
                8'd3: o_byte = TOTAL_LEN[15:8];
                8'd4: o_byte = 8'h04;                              // four interfaces
                8'd5: o_byte = 8'h01;                              // config value
                8'd6: o_byte = 8'h00;                              // no string
                8'd7: o_byte = (`USB_SELF_POWERED != 0) ? 8'hC0 : 8'h80;
                default: o_byte = 8'hFA;                           // 500 mA
            endcase
        end else if (i_offset < IF_START) begin
            case (i_offset - IAD_START)
                8'd0: o_byte = 8'h08;
                8'd1: o_byte = usb_std_pkg::DT_IAD;
                8'd2: o_byte = 8'h00;                              // first interface
                8'd3: o_byte = 8'h02;                              // interface count
                8'd4: o_byte = usb_std_pkg::CLASS_CDC;
                8'd5: o_byte = usb_std_pkg::CDC_SUBCLASS_ACM;
                default: o_byte = 8'h00;                           // protocol, iFunction
            endcase
        end else if (i_offset < IF_START + 4 * IF_LEN) begin
            if (rel < 9) begin
                case (rel)
                    0: o_byte = 8'h09;
                    1: o_byte = usb_std_pkg::DT_INTERFACE;
                    2: o_byte = n;
                    4: o_byte = 8'h02;                             // two endpoints
                    5: o_byte = cdc ? usb_std_pkg::CLASS_CDC : usb_std_pkg::CLASS_NONE;
                    6: o_byte = cdc ? usb_std_pkg::CDC_SUBCLASS_ACM : 8'h00;
                    default: o_byte = 8'h00;                       // alt, protocol, string
                endcase
            end else begin
                case (ep)
                    0: o_byte = 8'h07;
                    1: o_byte = usb_std_pkg::DT_ENDPOINT;
                    2: o_byte = is_out ? n + 8'd1 : 8'h80 | (n + 8'd1);
                    3: o_byte = 8'h02;                             // bulk
                    5: o_byte = 8'h02;                             // 512 byte packets
                    default: o_byte = 8'h00;                       // mps lo, interval
                endcase
            end
        end
    end

endmodule

// File: str_desc_gen.sv
// UTF-16LE string descriptor
`timescale 1ns/10ps

module str_desc_gen #(
    parameter type text_t = logic [7:0]      // packed ascii, first char on top
) (
    input  text_t                    i_text,
    input  desc_map_pkg::desc_byte_t i_offset,
    output desc_map_pkg::desc_byte_t o_byte
);

    localparam int NCHAR = $bits(text_t) / 8;
    localparam int SLEN  = 2 + 2 * NCHAR;    // bLength

    always_comb begin
        int idx;  // character index

        idx = (int'(i_offset) - 2) / 2;
        if (i_offset == 8'd0) begin
            o_byte = 8'(SLEN);
        end else if (i_offset == 8'd1) begin
            o_byte = usb_std_pkg::DT_STRING;
        end else if (!i_offset[0] && i_offset < SLEN) begin
            o_byte = i_text[(NCHAR - 1 - idx) * 8 +: 8];  // low byte of utf-16 unit
        end else begin
            o_byte = 8'h00;                              // high bytes, past end
        end
    end

    // ascii only, every utf-16 high byte stays zero
    always_comb begin
        if (i_offset[0] && i_offset > 8'd1)
            a_odd_zero: assert (o_byte == 8'h00)
                else $error("odd string offset %0d gave %h", i_offset, o_byte);
    end

endmodule

// File: desc_read_mux.sv
// descriptor ROM address decode
`timescale 1ns/10ps
`include "usb_desc_defines.svh"

module desc_read_mux (
    input  desc_map_pkg::desc_addr_t i_raddr,
    input  desc_map_pkg::desc_byte_t i_dev_byte,
    input  desc_map_pkg::desc_byte_t i_qual_byte,
    input  desc_map_pkg::desc_byte_t i_hscfg_byte,
    input  desc_map_pkg::desc_byte_t i_vendor_byte,
    input  desc_map_pkg::desc_byte_t i_product_byte,
    input  desc_map_pkg::desc_byte_t i_serial_byte,
    output desc_map_pkg::desc_byte_t o_dev_offset,
    output desc_map_pkg::desc_byte_t o_qual_offset,
    output desc_map_pkg::desc_byte_t o_hscfg_offset,
    output desc_map_pkg::desc_byte_t o_vendor_offset,
    output desc_map_pkg::desc_byte_t o_product_offset,
    output desc_map_pkg::desc_byte_t o_serial_offset,
    output desc_map_pkg::desc_byte_t o_rdat
);

    logic [6:0]                 hit;     // raw range compare per region
    logic                       in_rom;  // below end of table
    desc_map_pkg::desc_region_e region;
    desc_map_pkg::desc_addr_t   base;    // base of decoded region
    desc_map_pkg::desc_byte_t   offset;
    desc_map_pkg::desc_byte_t   lang_byte;

    assign in_rom = i_raddr < `DESC_END_ADDR;
    assign hit[0] = i_raddr >= `DESC_DEV_ADDR && i_raddr < `DESC_DEV_ADDR + `DESC_DEV_LEN;
    assign hit[1] = i_raddr >= `DESC_QUAL_ADDR && i_raddr < `DESC_QUAL_ADDR + `DESC_QUAL_LEN;
    assign hit[2] = i_raddr >= `DESC_HSCFG_ADDR && i_raddr < `DESC_STRLANG_ADDR;
    assign hit[3] = i_raddr >= `DESC_STRLANG_ADDR && i_raddr < `DESC_STRVENDOR_ADDR;
    assign hit[4] = i_raddr >= `DESC_STRVENDOR_ADDR && i_raddr < `DESC_STRPRODUCT_ADDR;
    assign hit[5] = i_raddr >= `DESC_STRPRODUCT_ADDR && i_raddr < `DESC_STRSERIAL_ADDR;
    assign hit[6] = i_raddr >= `DESC_STRSERIAL_ADDR && in_rom;

    always_comb begin
        region = desc_map_pkg::REG_NONE;  // padding and out of range
        base   = '0;
        if (hit[0]) begin
            region = desc_map_pkg::REG_DEV;
            base   = `DESC_DEV_ADDR;
        end else if (hit[1]) begin
            region = desc_map_pkg::REG_QUAL;
            base   = `DESC_QUAL_ADDR;
        end else if (hit[2]) begin
            region = desc_map_pkg::REG_HSCFG;
            base   = `DESC_HSCFG_ADDR;
        end else if (hit[3]) begin
            region = desc_map_pkg::REG_LANG;
            base   = `DESC_STRLANG_ADDR;
        end else if (hit[4]) begin
            region = desc_map_pkg::REG_VENDOR;
            base   = `DESC_STRVENDOR_ADDR;
        end else if (hit[5]) begin
            region = desc_map_pkg::REG_PRODUCT;
            base   = `DESC_STRPRODUCT_ADDR;
        end else if (hit[6]) begin
            region = desc_map_pkg::REG_SERIAL;
            base   = `DESC_STRSERIAL_ADDR;
        end
    end

    assign offset = desc_map_pkg::desc_byte_t'(i_raddr - base);  // regions < 256 bytes

    // same offset to every generator, only the decoded one is used
    assign o_dev_offset     = offset;
    assign o_qual_offset    = offset;
    assign o_hscfg_offset   = offset;
    assign o_vendor_offset  = offset;
    assign o_product_offset = offset;
    assign o_serial_offset  = offset;

    // string 0, english us only
    always_comb begin
        case (offset[1:0])
            2'd0: lang_byte = 8'h04;
            2'd1: lang_byte = usb_std_pkg::DT_STRING;
            2'd2: lang_byte = 8'h09;   // langid 0409
            default: lang_byte = 8'h04;
        endcase
    end

    always_comb begin
        case (region)
            desc_map_pkg::REG_DEV:     o_rdat = i_dev_byte;
            desc_map_pkg::REG_QUAL:    o_rdat = i_qual_byte;
            desc_map_pkg::REG_HSCFG:   o_rdat = i_hscfg_byte;
            desc_map_pkg::REG_LANG:    o_rdat = lang_byte;
            desc_map_pkg::REG_VENDOR:  o_rdat = i_vendor_byte;
            desc_map_pkg::REG_PRODUCT: o_rdat = i_product_byte;
            desc_map_pkg::REG_SERIAL:  o_rdat = i_serial_byte;
            default:                   o_rdat = 8'h00;
        endcase
    end

    // layout check, regions never overlap and nothing lies past the end
    always_comb begin
        a_one_region: assert ($onehot0(hit) && (in_rom || hit == '0))
            else $error("address %0d maps to regions %b", i_raddr, hit);
    end

endmodule

// File: usb_desc_top.sv
// USB descriptor ROM top
`timescale 1ns/10ps
`include "usb_desc_defines.svh"

module usb_desc_top (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic [15:0]              i_vid,            // 0000/ffff keep default
    input  logic [15:0]              i_pid,
    input  desc_map_pkg::desc_addr_t i_descrom_raddr,
    output desc_map_pkg::desc_byte_t o_descrom_rdat    // same-cycle read data
);

    localparam desc_map_pkg::vendor_text_t  VENDOR_TEXT  = `USB_VENDOR_STR;
    localparam desc_map_pkg::product_text_t PRODUCT_TEXT = `USB_PRODUCT_STR;
    localparam desc_map_pkg::serial_text_t  SERIAL_TEXT  = `USB_SERIAL_STR;

    desc_map_pkg::desc_byte_t dev_offset,     dev_byte;
    desc_map_pkg::desc_byte_t qual_offset,    qual_byte;
    desc_map_pkg::desc_byte_t hscfg_offset,   hscfg_byte;
    desc_map_pkg::desc_byte_t vendor_offset,  vendor_byte;
    desc_map_pkg::desc_byte_t product_offset, product_byte;
    desc_map_pkg::desc_byte_t serial_offset,  serial_byte;

    dev_desc_gen u_dev (
        .CLK           (CLK),
        .RESET         (RESET),
        .i_vid         (i_vid),
        .i_pid         (i_pid),
        .i_dev_offset  (dev_offset),
        .i_qual_offset (qual_offset),
        .o_dev_byte    (dev_byte),
        .o_qual_byte   (qual_byte)
    );

    hs_cfg_desc u_hscfg (
        .i_offset (hscfg_offset),
        .o_byte   (hscfg_byte)
    );

    str_desc_gen #(.text_t(desc_map_pkg::vendor_text_t)) u_str_vendor (
        .i_text   (VENDOR_TEXT),
        .i_offset (vendor_offset),
        .o_byte   (vendor_byte)
    );

    str_desc_gen #(.text_t(desc_map_pkg::product_text_t)) u_str_product (
        .i_text   (PRODUCT_TEXT),
        .i_offset (product_offset),
        .o_byte   (product_byte)
    );

    str_desc_gen #(.text_t(desc_map_pkg::serial_text_t)) u_str_serial (
        .i_text   (SERIAL_TEXT),
        .i_offset (serial_offset),
        .o_byte   (serial_byte)
    );

    desc_read_mux u_mux (
        .i_raddr          (i_descrom_raddr),
        .i_dev_byte       (dev_byte),
        .i_qual_byte      (qual_byte),
        .i_hscfg_byte     (hscfg_byte),
        .i_vendor_byte    (vendor_byte),
        .i_product_byte   (product_byte),
        .i_serial_byte    (serial_byte),
        .o_dev_offset     (dev_offset),
        .o_qual_offset    (qual_offset),
        .o_hscfg_offset   (hscfg_offset),
        .o_vendor_offset  (vendor_offset),
        .o_product_offset (product_offset),
        .o_serial_offset  (serial_offset),
        .o_rdat           (o_descrom_rdat)
    );

endmodule

// File: tb_clkgen.sv
// testbench clock and reset
`timescale 1ns/10ps

module tb_clkgen #(
    parameter int PERIOD       = 8,  // ns
    parameter int RESET_CYCLES = 3
) (
    output logic CLK,
    output logic RESET
);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;   // free running
    end

    initial begin
        RESET = 1'b1;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);                     // release away from the active edge
        RESET = 1'b0;
    end

endmodule

// File: tb_desc_checker.sv
// descriptor ROM reference model
`timescale 1ns/10ps
`include "usb_desc_defines.svh"

module tb_desc_checker #(
    parameter int SAMPLE_DLY = 3                 // ns after rise, before the fall
) (
    input  logic                     CLK,
    input  logic                     RESET,
    input  logic [15:0]              i_vid,
    input  logic [15:0]              i_pid,
    input  desc_map_pkg::desc_addr_t i_raddr,
    input  desc_map_pkg::desc_byte_t i_rdat,
    input  logic                     i_check_en,
    input  logic [3:0]               i_test_id,
    input  logic                     i_test_done,   // pulse at the end of a test
    input  int                       i_aux_errs,    // found by the stimulus side
    output int                       o_checks,
    output int                       o_errors
);

    localparam int          DEPTH = 1 << `DESC_ADDR_W;
    localparam logic [15:0] BCD   = `USB_VERSION_BCD;
    localparam logic [7:0]  ATTR  = (`USB_SELF_POWERED != 0) ? 8'hC0 : 8'h80;

    logic [7:0]  rom [0:DEPTH-1];   // expected image, ids patched on compare
    logic [15:0] m_vid;             // model of the stored ids
    logic [15:0] m_pid;
    logic [7:0]  exp_b;
    int          wp;                // table fill pointer
    int          n_checks;
    int          cmp_errs;
    int          chk_mark;          // counts at the start of the test
    int          err_mark;

    function automatic logic [15:0] id_or_default(input logic [15:0] id,
                                                  input logic [15:0] dflt);
        return (id == 16'h0000 || id == 16'hFFFF) ? dflt : id;  // unprogrammed
    endfunction

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd1:    return "device defaults";
            4'd2:    return "id override";
            4'd3:    return "config walk";
            4'd4:    return "strings";
            default: return "random reads";
        endcase
    endfunction

    task automatic put(input logic [7:0] b);
        rom[wp] = b;
        wp++;
    endtask

    // low n bytes of v, first byte on top
    task automatic put_bytes(input logic [79:0] v, input int n);
        for (int i = n - 1; i >= 0; i--) begin
            put(v[8*i +: 8]);
        end
    endtask

    task automatic put_str(input string s);
        put(8'(2 + 2 * s.len()));     // bLength
        put(8'h03);
        for (int i = 0; i < s.len(); i++) begin
            put(s[i]);
            put(8'h00);               // utf-16 high byte
        end
    endtask

    function automatic logic [7:0] expected_byte(input int a);
        case (a)
            `DESC_DEV_ADDR + 8:  return m_vid[7:0];
            `DESC_DEV_ADDR + 9:  return m_vid[15:8];
            `DESC_DEV_ADDR + 10: return m_pid[7:0];
            `DESC_DEV_ADDR + 11: return m_pid[15:8];
            default:             return rom[a];
        endcase
    endfunction

    initial begin
        logic [7:0] cdc;              // class and subclass of an interface
        n_checks = 0;
        cmp_errs = 0;
        chk_mark = 0;
        err_mark = 0;
        for (int a = 0; a < DEPTH; a++) begin
            rom[a] = 8'h00;           // padding and past the end
        end
        wp = `DESC_DEV_ADDR;
        put_bytes({8'h12, 8'h01, 8'h00, 8'h02, 8'hEF, 8'h02, 8'h01, 8'h40}, 8);
        put_bytes(32'h0, 4);          // id slots
        put_bytes({BCD[7:0], BCD[15:8], 8'h01, 8'h02, 8'h03, 8'h01}, 6);
        wp = `DESC_QUAL_ADDR;
        put_bytes({8'h0A, 8'h06, 8'h00, 8'h02, 8'hEF, 8'h02, 8'h01, 8'h40, 8'h01, 8'h00}, 10);
        wp = `DESC_HSCFG_ADDR;
        put_bytes({8'h09, 8'h02, 8'h6D, 8'h00, 8'h04, 8'h01, 8'h00, ATTR, 8'hFA}, 9);
        put_bytes({8'h08, 8'h0B, 8'h00, 8'h02, 8'h02, 8'h02, 8'h00, 8'h00}, 8);  // iad
        for (int n = 0; n < 4; n++) begin
            cdc = (n == 1 || n == 2) ? 8'h02 : 8'h00;
            put_bytes({8'h09, 8'h04, 8'(n), 8'h00, 8'h02, cdc, cdc, 8'h00, 8'h00}, 9);
            put_bytes({8'h07, 8'h05, 8'h80 | 8'(n + 1), 8'h02, 8'h00, 8'h02, 8'h00}, 7);
            put_bytes({8'h07, 8'h05, 8'(n + 1), 8'h02, 8'h00, 8'h02, 8'h00}, 7);
        end
        put_bytes({8'h04, 8'h03, 8'h09, 8'h04}, 4);  // string 0, langid 0409
        put_str(`USB_VENDOR_STR);
        put_str(`USB_PRODUCT_STR);
        put_str(`USB_SERIAL_STR);
    end

    always @(posedge CLK or posedge RESET) begin
        if (RESET) begin
            m_vid <= `USB_VENDOR_ID;
            m_pid <= `USB_PRODUCT_ID;
        end else begin
            m_vid <= id_or_default(i_vid, `USB_VENDOR_ID);
            m_pid <= id_or_default(i_pid, `USB_PRODUCT_ID);
        end
    end

    // read data settled, address and ids stable until the fall
    always @(posedge CLK) begin
        if (!RESET && i_check_en) begin
            #(SAMPLE_DLY);
            exp_b = expected_byte(int'(i_raddr));
            n_checks++;
            if (i_rdat !== exp_b) begin
                cmp_errs++;
                $display("** Error at %0d ns: addr %0d read %h, expected %h",
                         $time, i_raddr, i_rdat, exp_b);
            end
        end
    end

    assign o_checks = n_checks;
    assign o_errors = cmp_errs + i_aux_errs;

    always @(posedge i_test_done) begin
        $display("test %0d %s: %0d checks, %0d errors, %s", i_test_id, test_name(i_test_id),
                 n_checks - chk_mark, o_errors - err_mark,
                 (o_errors == err_mark) ? "ok" : "FAIL");
        chk_mark = n_checks;
        err_mark = o_errors;
    end

endmodule

// File: tb_usb_desc.sv
// descriptor ROM testbench top
`timescale 1ns/10ps
`include "usb_desc_defines.svh"

module tb_usb_desc;

    localparam int RESET_WAIT = 16;   // cycles allowed for reset release
    localparam int N_ID       = 40;   // id override rounds
    localparam int N_RND      = 300;  // random reads

    logic                     CLK;
    logic                     RESET;
    logic [15:0]              vid;
    logic [15:0]              pid;
    desc_map_pkg::desc_addr_t raddr;
    desc_map_pkg::desc_byte_t rdat;
    logic                     check_en;
    logic [3:0]               test_id;
    logic                     test_done;
    int                       walk_errs;  // structural errors of the config walk
    int                       checks;
    int                       errors;
    logic [31:0]              rng;        // xorshift state

    tb_clkgen u_clk (
        .CLK   (CLK),
        .RESET (RESET)
    );

    usb_desc_top dut (
        .CLK             (CLK),
        .RESET           (RESET),
        .i_vid           (vid),
        .i_pid           (pid),
        .i_descrom_raddr (raddr),
        .o_descrom_rdat  (rdat)
    );

    tb_desc_checker u_chk (
        .CLK         (CLK),
        .RESET       (RESET),
        .i_vid       (vid),
        .i_pid       (pid),
        .i_raddr     (raddr),
        .i_rdat      (rdat),
        .i_check_en  (check_en),
        .i_test_id   (test_id),
        .i_test_done (test_done),
        .i_aux_errs  (walk_errs),
        .o_checks    (checks),
        .o_errors    (errors)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic roll(output logic [31:0] r);
        rng = xorshift32(rng);
        r   = rng;
    endtask

    task automatic pick_id(output logic [15:0] id);
        logic [31:0] r;
        roll(r);
        if (r[1:0] == 2'b00)
            id = r[2] ? 16'hFFFF : 16'h0000;  // one in four unprogrammed
        else
            id = r[31:16];
    endtask

    task automatic drive_addr(input int a);
        @(negedge CLK);
        raddr = desc_map_pkg::desc_addr_t'(a);
    endtask

    task automatic read_byte(input int a, output int d);
        drive_addr(a);
        @(negedge CLK);
        d = int'(rdat);                       // settled for a half cycle
    endtask

    task automatic walk_check(input string what, input int got, input int exp);
        if (got != exp) begin
            walk_errs++;
            $display("** Error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input int id);
        @(negedge CLK);
        test_id   = 4'(id);
        @(negedge CLK);
        test_done = 1'b1;                     // checker prints the test line
        @(negedge CLK);
        test_done = 1'b0;
    endtask

    task automatic id_override_test();
        logic [15:0] v;
        logic [15:0] p;
        for (int i = 0; i < N_ID; i++) begin
            pick_id(v);
            pick_id(p);
            @(negedge CLK);
            vid   = v;
            pid   = p;
            raddr = `DESC_DEV_ADDR + 8;       // first edge after the change
            for (int a = 9; a < 12; a++) begin
                drive_addr(`DESC_DEV_ADDR + a);
            end
        end
        end_test(2);
    endtask

    task automatic cfg_walk_test();
        int base;
        int pos;
        int len;
        int dtype;
        int field;
        int ifc;      // interfaces seen so far
        int eps;      // endpoints seen so far
        int wtotal;
        base = `DESC_HSCFG_ADDR;
        pos  = 0;
        ifc  = 0;
        eps  = 0;
        read_byte(base + 2, wtotal);
        read_byte(base + 3, field);
        wtotal = wtotal + (field << 8);
        for (int k = 0; k < 32 && pos < `DESC_HSCFG_LEN; k++) begin
            read_byte(base + pos, len);
            read_byte(base + pos + 1, dtype);
            if (len == 0) begin
                walk_errs++;
                $display("** Error at %0d ns: zero bLength at offset %0d", $time, pos);
                break;
            end
            if (dtype == int'(usb_std_pkg::DT_INTERFACE)) begin
                read_byte(base + pos + 2, field);
                walk_check("bInterfaceNumber", field, ifc);
                ifc++;
            end else if (dtype == int'(usb_std_pkg::DT_ENDPOINT)) begin
                read_byte(base + pos + 2, field);
                walk_check("bEndpointAddress", field, (eps % 2 == 0) ? 128 + ifc : ifc);
                eps++;
            end
            pos = pos + len;
        end
        walk_check("sum of bLength", pos, `DESC_HSCFG_LEN);
        walk_check("wTotalLength", wtotal, `DESC_HSCFG_LEN);
        walk_check("interface count", ifc, 4);
        walk_check("endpoint count", eps, 8);
        end_test(3);
    endtask

    initial begin
        logic [31:0] r;
        int          n;
        vid       = 16'h0000;
        pid       = 16'h0000;
        raddr     = '0;
        check_en  = 1'b0;
        test_id   = 4'd0;
        test_done = 1'b0;
        walk_errs = 0;
        rng       = 32'hb21d2c05;
        for (n = 0; n < RESET_WAIT && RESET !== 1'b0; n++) begin
            @(negedge CLK);
        end
        if (RESET !== 1'b0) begin
            $display("reset was not released within %0d cycles", RESET_WAIT);
            $display("Regression failed");
            $finish;
        end else begin
            check_en = 1'b1;
            for (int a = 0; a < `DESC_DEV_LEN; a++) begin
                drive_addr(`DESC_DEV_ADDR + a);
            end
            for (int a = 0; a < `DESC_QUAL_LEN; a++) begin
                drive_addr(`DESC_QUAL_ADDR + a);
            end
            end_test(1);
            id_override_test();
            cfg_walk_test();
            for (int a = `DESC_STRLANG_ADDR; a < `DESC_END_ADDR; a++) begin
                drive_addr(a);                // language and text strings
            end
            end_test(4);
            for (int i = 0; i < N_RND; i++) begin
                roll(r);
                drive_addr(int'(r[`DESC_ADDR_W-1:0]));
            end
            end_test(5);
            @(negedge CLK);
            $display("5 tests, %0d checks, %0d errors", checks, errors);
            if (errors == 0 && checks > 0) begin
                $display("Regression passed");
            end else begin
                $display("Regression failed");
            end
            $finish;
        end
    end

endmodule

// File: sim.f
+incdir+.
usb_std_pkg.sv
desc_map_pkg.sv
dev_desc_gen.sv
hs_cfg_desc.sv
str_desc_gen.sv
desc_read_mux.sv
usb_desc_top.sv
tb_clkgen.sv
tb_desc_checker.sv
tb_usb_desc.sv

// File: Makefile
# Verilator build and run of the descriptor ROM testbench
SIM := obj_dir/Vtb_usb_desc

all: run

# rebuilt only when a source or the file list changes
$(SIM): sim.f usb_desc_defines.svh $(wildcard *.sv)
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_usb_desc -o Vtb_usb_desc

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
